// File: design/csr_pkg.sv
package csr_pkg;

    parameter int CSR_ADDR_SIZE = 12;

    typedef enum logic [2:0] {
        NOPE  = 3'd0,
        READ  = 3'd1,
        WRITE = 3'd2,
        SET   = 3'd3,
        CLEAR = 3'd4,
        SYS   = 3'd5
    } csr_cmd_t;

    // Same 12 bits, seen as an index or as the standard access fields
    typedef union packed {
        logic [CSR_ADDR_SIZE-1:0] raw;
        struct packed {
            logic [1:0] access;
            logic [1:0] priv;
            logic [7:0] num;
        } fields;
    } csr_addr_u;

    // Machine-mode CSR addresses
    parameter logic [CSR_ADDR_SIZE-1:0] CSR_MSTATUS  = 12'h300;
    parameter logic [CSR_ADDR_SIZE-1:0] CSR_MTVEC    = 12'h305;
    parameter logic [CSR_ADDR_SIZE-1:0] CSR_MSCRATCH = 12'h340;
    parameter logic [CSR_ADDR_SIZE-1:0] CSR_MEPC     = 12'h341;
    parameter logic [CSR_ADDR_SIZE-1:0] CSR_MCAUSE   = 12'h342;
    parameter logic [CSR_ADDR_SIZE-1:0] CSR_MTVAL    = 12'h343;
    parameter logic [CSR_ADDR_SIZE-1:0] CSR_MCYCLE   = 12'hB00;
    parameter logic [CSR_ADDR_SIZE-1:0] CSR_MINSTRET = 12'hB02;
    parameter logic [CSR_ADDR_SIZE-1:0] CSR_MHARTID  = 12'hF14;

    // System instruction codes, carried on the address of a SYS request
    parameter logic [CSR_ADDR_SIZE-1:0] SYS_ECALL  = 12'h000;
    parameter logic [CSR_ADDR_SIZE-1:0] SYS_EBREAK = 12'h001;
    parameter logic [CSR_ADDR_SIZE-1:0] SYS_WFI    = 12'h105;
    parameter logic [CSR_ADDR_SIZE-1:0] SYS_SFENCE = 12'h120;
    parameter logic [CSR_ADDR_SIZE-1:0] SYS_MRET   = 12'h302;

    // Trap causes
    parameter logic [5:0] CAUSE_ILLEGAL_INSTR = 6'd2;
    parameter logic [5:0] CAUSE_BREAKPOINT    = 6'd3;
    parameter logic [5:0] CAUSE_ECALL_M       = 6'd11;

endpackage

// File: design/commit_pkg.sv
package commit_pkg;

    parameter int XLEN = 64;

    typedef logic [XLEN-1:0] bus64_t;

    // Instruction classes that matter at commit
    typedef enum logic [3:0] {
        OTHER      = 4'd0,
        CSRRW      = 4'd1,
        CSRRS      = 4'd2,
        CSRRC      = 4'd3,
        CSRRWI     = 4'd4,
        CSRRSI     = 4'd5,
        CSRRCI     = 4'd6,
        ECALL      = 4'd7,
        EBREAK     = 4'd8,
        MRET       = 4'd9,
        WFI        = 4'd10,
        SFENCE_VMA = 4'd11
    } instr_type_t;

endpackage

// File: design/wb_commit_reg.sv
`timescale 1ns/1ps

module wb_commit_reg (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                stall_exe_i,
    input  logic                                flush_i,
    input  logic                                instr_valid_i,
    input  commit_pkg::instr_type_t             instr_type_i,
    input  commit_pkg::bus64_t                  pc_i,
    input  logic [4:0]                          rs1_i,
    input  logic [csr_pkg::CSR_ADDR_SIZE-1:0]   csr_addr_i,
    input  commit_pkg::bus64_t                  result_i,
    input  logic                                xcpt_valid_i,
    input  logic [5:0]                          xcpt_cause_i,
    input  commit_pkg::bus64_t                  xcpt_tval_i,
    output logic                                cm_valid_o,
    output commit_pkg::instr_type_t             cm_type_o,
    output commit_pkg::bus64_t                  cm_pc_o,
    output logic [4:0]                          cm_rs1_o,
    output logic [csr_pkg::CSR_ADDR_SIZE-1:0]   cm_addr_o,
    output commit_pkg::bus64_t                  cm_result_o,
    output logic                                cm_xcpt_o,
    output logic [5:0]                          cm_cause_o,
    output commit_pkg::bus64_t                  cm_tval_o
);

    logic bubble;

    // A stall or a redirect at commit turns this slot into a bubble
    assign bubble = stall_exe_i | flush_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cm_valid_o <= 1'b0;
            cm_xcpt_o  <= 1'b0;
        end else if (bubble) begin
            cm_valid_o <= 1'b0;
            cm_xcpt_o  <= 1'b0;
        end else begin
            cm_valid_o <= instr_valid_i;
            cm_xcpt_o  <= instr_valid_i & xcpt_valid_i;
        end
    end

    // Instruction fields, held while the execute stage stalls
    always_ff @(posedge clk_i) begin
        if (!stall_exe_i) begin
            cm_type_o   <= instr_type_i;
            cm_pc_o     <= pc_i;
            cm_rs1_o    <= rs1_i;
            cm_addr_o   <= csr_addr_i;
            cm_result_o <= result_i;
            cm_cause_o  <= xcpt_cause_i;
            cm_tval_o   <= xcpt_tval_i;
        end
    end

endmodule

// File: design/csr_interface.sv
`timescale 1ns/1ps

module csr_interface (
    input  logic                                valid_i,
    input  commit_pkg::instr_type_t             instr_type_i,
    input  commit_pkg::bus64_t                  pc_i,
    input  logic [4:0]                          rs1_i,
    input  logic [csr_pkg::CSR_ADDR_SIZE-1:0]   csr_addr_i,
    input  commit_pkg::bus64_t                  result_i,
    input  logic                                xcpt_valid_i,
    input  logic [5:0]                          xcpt_cause_i,
    input  commit_pkg::bus64_t                  xcpt_tval_i,
    output logic                                csr_ena_o,
    output csr_pkg::csr_cmd_t                   csr_cmd_o,
    output logic [csr_pkg::CSR_ADDR_SIZE-1:0]   csr_addr_o,
    output commit_pkg::bus64_t                  csr_wdata_o,
    output commit_pkg::bus64_t                  csr_pc_o,
    output logic                                csr_exception_o,
    output logic [5:0]                          csr_cause_o,
    output commit_pkg::bus64_t                  csr_tval_o,
    output logic                                csr_retire_o
);

    logic                               ena;
    csr_pkg::csr_cmd_t                  cmd;
    logic [csr_pkg::CSR_ADDR_SIZE-1:0]  addr;
    commit_pkg::bus64_t                 wdata;
    commit_pkg::bus64_t                 uimm;
    logic                               rs1_zero;

    assign uimm     = {{(commit_pkg::XLEN-5){1'b0}}, rs1_i};
    assign rs1_zero = (rs1_i == 5'd0);

    always_comb begin
        ena   = 1'b0;
        cmd   = csr_pkg::NOPE;
        addr  = csr_addr_i;
        wdata = result_i;
        if (valid_i) begin
            ena = 1'b1;
            case (instr_type_i)
                commit_pkg::CSRRW:  cmd = csr_pkg::WRITE;
                commit_pkg::CSRRS:  cmd = rs1_zero ? csr_pkg::READ : csr_pkg::SET;
                commit_pkg::CSRRC:  cmd = rs1_zero ? csr_pkg::READ : csr_pkg::CLEAR;
                commit_pkg::CSRRWI: begin
                    cmd   = csr_pkg::WRITE;
                    wdata = uimm;
                end
                commit_pkg::CSRRSI: begin
                    cmd   = rs1_zero ? csr_pkg::READ : csr_pkg::SET;
                    wdata = uimm;
                end
                commit_pkg::CSRRCI: begin
                    cmd   = rs1_zero ? csr_pkg::READ : csr_pkg::CLEAR;
                    wdata = uimm;
                end
                // System ops tell the CSR file what they are through the address
                commit_pkg::ECALL:      addr = csr_pkg::SYS_ECALL;
                commit_pkg::EBREAK:     addr = csr_pkg::SYS_EBREAK;
                commit_pkg::MRET:       addr = csr_pkg::SYS_MRET;
                commit_pkg::WFI:        addr = csr_pkg::SYS_WFI;
                commit_pkg::SFENCE_VMA: addr = csr_pkg::SYS_SFENCE;
                default: ena = 1'b0;
            endcase
            if (ena && cmd == csr_pkg::NOPE) begin
                cmd   = csr_pkg::SYS;
                wdata = '0;
            end
        end
    end

    assign csr_ena_o   = ena;
    assign csr_cmd_o   = ena ? cmd : csr_pkg::NOPE;
    assign csr_addr_o  = ena ? addr : '0;
    // Without a request the data lane carries the faulting value
    assign csr_wdata_o = ena ? wdata : xcpt_tval_i;

    assign csr_pc_o        = pc_i;
    assign csr_exception_o = valid_i & xcpt_valid_i;
    assign csr_cause_o     = xcpt_cause_i;
    assign csr_tval_o      = xcpt_tval_i;
    assign csr_retire_o    = valid_i & ~xcpt_valid_i;

endmodule

// File: design/csr_regfile.sv
`timescale 1ns/1ps

module csr_regfile #(
    parameter logic [63:0] HART_ID     = 64'h0,
    parameter logic [63:0] RESET_MTVEC = 64'h100
) (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                csr_ena_i,
    input  csr_pkg::csr_cmd_t                   csr_cmd_i,
    input  logic [csr_pkg::CSR_ADDR_SIZE-1:0]   csr_addr_i,
    input  commit_pkg::bus64_t                  csr_wdata_i,
    input  commit_pkg::bus64_t                  csr_pc_i,
    input  logic                                csr_exception_i,
    input  logic [5:0]                          csr_cause_i,
    input  commit_pkg::bus64_t                  csr_tval_i,
    input  logic                                csr_retire_i,
    output commit_pkg::bus64_t                  rdata_o,
    output logic                                rdata_valid_o,
    output logic                                redirect_o,
    output commit_pkg::bus64_t                  redirect_pc_o
);

    csr_pkg::csr_addr_u addr;

    logic               mie;
    logic               mpie;
    commit_pkg::bus64_t mtvec;
    commit_pkg::bus64_t mepc;
    logic [5:0]         mcause;
    commit_pkg::bus64_t mtval;
    commit_pkg::bus64_t mscratch;
    commit_pkg::bus64_t mcycle;
    commit_pkg::bus64_t minstret;

    commit_pkg::bus64_t old_val;
    commit_pkg::bus64_t new_val;
    logic               known;
    logic               is_access;
    logic               is_modify;
    logic               illegal;
    logic               sys;
    logic               ecall;
    logic               ebreak;
    logic               mret;
    logic               trap;
    logic               do_write;
    logic [5:0]         trap_cause;

    assign addr.raw = csr_addr_i;

    // Current value and existence of the addressed CSR
    always_comb begin
        known   = 1'b1;
        old_val = '0;
        case (addr.raw)
            csr_pkg::CSR_MSTATUS:  old_val = {56'b0, mpie, 3'b0, mie, 3'b0};
            csr_pkg::CSR_MTVEC:    old_val = mtvec;
            csr_pkg::CSR_MEPC:     old_val = mepc;
            csr_pkg::CSR_MCAUSE:   old_val = {58'b0, mcause};
            csr_pkg::CSR_MTVAL:    old_val = mtval;
            csr_pkg::CSR_MSCRATCH: old_val = mscratch;
            csr_pkg::CSR_MHARTID:  old_val = HART_ID;
            csr_pkg::CSR_MCYCLE:   old_val = mcycle;
            csr_pkg::CSR_MINSTRET: old_val = minstret;
            default:               known   = 1'b0;
        endcase
    end

    assign is_access = csr_ena_i & (csr_cmd_i == csr_pkg::READ  | csr_cmd_i == csr_pkg::WRITE |
                                    csr_cmd_i == csr_pkg::SET   | csr_cmd_i == csr_pkg::CLEAR);
    assign is_modify = is_access & (csr_cmd_i != csr_pkg::READ);

    // Access field 3 marks the read-only space
    assign illegal = is_modify & (~known | (addr.fields.access == 2'b11));

    assign sys    = csr_ena_i & (csr_cmd_i == csr_pkg::SYS);
    assign ecall  = sys & (addr.raw == csr_pkg::SYS_ECALL);
    assign ebreak = sys & (addr.raw == csr_pkg::SYS_EBREAK);
    assign mret   = sys & (addr.raw == csr_pkg::SYS_MRET);

    assign trap     = csr_exception_i | ecall | ebreak | illegal;
    assign do_write = is_modify & ~trap;

    always_comb begin
        if (csr_exception_i) begin
            trap_cause = csr_cause_i;
        end else if (ecall) begin
            trap_cause = csr_pkg::CAUSE_ECALL_M;
        end else if (ebreak) begin
            trap_cause = csr_pkg::CAUSE_BREAKPOINT;
        end else begin
            trap_cause = csr_pkg::CAUSE_ILLEGAL_INSTR;
        end
    end

    always_comb begin
        case (csr_cmd_i)
            csr_pkg::SET:   new_val = old_val | csr_wdata_i;
            csr_pkg::CLEAR: new_val = old_val & ~csr_wdata_i;
            default:        new_val = csr_wdata_i;
        endcase
    end

    assign rdata_valid_o = is_access & ~trap;
    assign rdata_o       = rdata_valid_o ? old_val : '0;
    assign redirect_o    = trap | mret;
    // Trap goes to the mtvec base, direct mode only
    assign redirect_pc_o = trap ? {mtvec[63:2], 2'b00} : (mret ? mepc : '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mie      <= 1'b0;
            mpie     <= 1'b0;
            mtvec    <= RESET_MTVEC;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mscratch <= '0;
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle <= mcycle + 1'b1;
            if (csr_retire_i && !trap) begin
                minstret <= minstret + 1'b1;
            end
            if (trap) begin
                mepc   <= csr_pc_i;
                mcause <= trap_cause;
                mtval  <= csr_exception_i ? csr_tval_i : '0;
                mpie   <= mie;
                mie    <= 1'b0;
            end else if (mret) begin
                mie  <= mpie;
                mpie <= 1'b1;
            end else if (do_write) begin
                // Software write wins over the counters
                case (addr.raw)
                    csr_pkg::CSR_MSTATUS: begin
                        mie  <= new_val[3];
                        mpie <= new_val[7];
                    end
                    csr_pkg::CSR_MTVEC:    mtvec    <= new_val;
                    csr_pkg::CSR_MEPC:     mepc     <= new_val;
                    csr_pkg::CSR_MCAUSE:   mcause   <= new_val[5:0];
                    csr_pkg::CSR_MTVAL:    mtval    <= new_val;
                    csr_pkg::CSR_MSCRATCH: mscratch <= new_val;
                    csr_pkg::CSR_MCYCLE:   mcycle   <= new_val;
                    csr_pkg::CSR_MINSTRET: minstret <= new_val;
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: design/csr_subsystem.sv
`timescale 1ns/1ps

module csr_subsystem #(
    parameter logic [63:0] HART_ID     = 64'h0,
    parameter logic [63:0] RESET_MTVEC = 64'h100
) (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                instr_valid_i,
    input  commit_pkg::instr_type_t             instr_type_i,
    input  commit_pkg::bus64_t                  pc_i,
    input  logic [4:0]                          rs1_i,
    input  logic [csr_pkg::CSR_ADDR_SIZE-1:0]   csr_addr_i,
    input  commit_pkg::bus64_t                  result_i,
    input  logic                                xcpt_valid_i,
    input  logic [5:0]                          xcpt_cause_i,
    input  commit_pkg::bus64_t                  xcpt_tval_i,
    input  logic                                stall_exe_i,
    output commit_pkg::bus64_t                  csr_rdata_o,
    output logic                                csr_rdata_valid_o,
    output logic                                retire_o,
    output logic                                redirect_o,
    output commit_pkg::bus64_t                  redirect_pc_o
);

    // Commit stage
    logic                               cm_valid;
    commit_pkg::instr_type_t            cm_type;
    commit_pkg::bus64_t                 cm_pc;
    logic [4:0]                         cm_rs1;
    logic [csr_pkg::CSR_ADDR_SIZE-1:0]  cm_addr;
    commit_pkg::bus64_t                 cm_result;
    logic                               cm_xcpt;
    logic [5:0]                         cm_cause;
    commit_pkg::bus64_t                 cm_tval;

    // CSR request
    logic                               csr_ena;
    csr_pkg::csr_cmd_t                  csr_cmd;
    logic [csr_pkg::CSR_ADDR_SIZE-1:0]  csr_addr;
    commit_pkg::bus64_t                 csr_wdata;
    commit_pkg::bus64_t                 csr_pc;
    logic                               csr_exception;
    logic [5:0]                         csr_cause;
    commit_pkg::bus64_t                 csr_tval;
    logic                               csr_retire;

    logic                               redirect;

    assign retire_o   = csr_retire;
    assign redirect_o = redirect;

    wb_commit_reg wb_commit_reg_inst (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .stall_exe_i   (stall_exe_i),
        .flush_i       (redirect),
        .instr_valid_i (instr_valid_i),
        .instr_type_i  (instr_type_i),
        .pc_i          (pc_i),
        .rs1_i         (rs1_i),
        .csr_addr_i    (csr_addr_i),
        .result_i      (result_i),
        .xcpt_valid_i  (xcpt_valid_i),
        .xcpt_cause_i  (xcpt_cause_i),
        .xcpt_tval_i   (xcpt_tval_i),
        .cm_valid_o    (cm_valid),
        .cm_type_o     (cm_type),
        .cm_pc_o       (cm_pc),
        .cm_rs1_o      (cm_rs1),
        .cm_addr_o     (cm_addr),
        .cm_result_o   (cm_result),
        .cm_xcpt_o     (cm_xcpt),
        .cm_cause_o    (cm_cause),
        .cm_tval_o     (cm_tval)
    );

    csr_interface csr_interface_inst (
        .valid_i         (cm_valid),
        .instr_type_i    (cm_type),
        .pc_i            (cm_pc),
        .rs1_i           (cm_rs1),
        .csr_addr_i      (cm_addr),
        .result_i        (cm_result),
        .xcpt_valid_i    (cm_xcpt),
        .xcpt_cause_i    (cm_cause),
        .xcpt_tval_i     (cm_tval),
        .csr_ena_o       (csr_ena),
        .csr_cmd_o       (csr_cmd),
        .csr_addr_o      (csr_addr),
        .csr_wdata_o     (csr_wdata),
        .csr_pc_o        (csr_pc),
        .csr_exception_o (csr_exception),
        .csr_cause_o     (csr_cause),
        .csr_tval_o      (csr_tval),
        .csr_retire_o    (csr_retire)
    );

    csr_regfile #(
        .HART_ID     (HART_ID),
        .RESET_MTVEC (RESET_MTVEC)
    ) csr_regfile_inst (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .csr_ena_i       (csr_ena),
        .csr_cmd_i       (csr_cmd),
        .csr_addr_i      (csr_addr),
        .csr_wdata_i     (csr_wdata),
        .csr_pc_i        (csr_pc),
        .csr_exception_i (csr_exception),
        .csr_cause_i     (csr_cause),
        .csr_tval_i      (csr_tval),
        .csr_retire_i    (csr_retire),
        .rdata_o         (csr_rdata_o),
        .rdata_valid_o   (csr_rdata_valid_o),
        .redirect_o      (redirect),
        .redirect_pc_o   (redirect_pc_o)
    );

endmodule

// File: bench/csr_subsystem_tb.sv
`timescale 1ns/1ps

module csr_subsystem_tb;

    localparam logic [63:0] HART_ID     = 64'h0000_0000_0000_0007;
    localparam logic [63:0] RESET_MTVEC = 64'h0000_0000_8000_0100;
    // Reset plus the cycles each test needs, in test order
    localparam int RUN_CYCLES = 17 + 4 + 6 + 14 + 10 + 11 + 60;
    localparam int TIMEOUT    = 2 * RUN_CYCLES + 100;

    logic                    clk_i;
    logic                    arst_n_i;
    logic                    instr_valid_i;
    commit_pkg::instr_type_t instr_type_i;
    commit_pkg::bus64_t      pc_i;
    logic [4:0]              rs1_i;
    logic [11:0]             csr_addr_i;
    commit_pkg::bus64_t      result_i;
    logic                    xcpt_valid_i;
    logic [5:0]              xcpt_cause_i;
    commit_pkg::bus64_t      xcpt_tval_i;
    logic                    stall_exe_i;
    commit_pkg::bus64_t      csr_rdata_o;
    logic                    csr_rdata_valid_o;
    logic                    retire_o;
    logic                    redirect_o;
    commit_pkg::bus64_t      redirect_pc_o;

    // Shadow CSR state
    logic                    m_mie;
    logic                    m_mpie;
    commit_pkg::bus64_t      m_mtvec;
    commit_pkg::bus64_t      m_mepc;
    logic [5:0]              m_mcause;
    commit_pkg::bus64_t      m_mtval;
    commit_pkg::bus64_t      m_mscratch;
    commit_pkg::bus64_t      m_mcycle;
    commit_pkg::bus64_t      m_minstret;

    // Instruction the model holds at commit
    logic                    s_valid;
    commit_pkg::instr_type_t s_type;
    commit_pkg::bus64_t      s_pc;
    logic [4:0]              s_rs1;
    logic [11:0]             s_addr;
    commit_pkg::bus64_t      s_data;
    logic                    s_xcpt;
    logic [5:0]              s_cause;
    commit_pkg::bus64_t      s_tval;

    logic                    known;
    logic                    csr_op;
    logic                    modify;
    logic                    trap;
    logic                    mret;
    logic [5:0]              cause;
    commit_pkg::bus64_t      cur_val;
    commit_pkg::bus64_t      wr_val;
    commit_pkg::bus64_t      new_val;
    logic                    exp_retire;
    logic                    exp_redirect;
    commit_pkg::bus64_t      exp_rpc;
    logic                    exp_rvalid;
    commit_pkg::bus64_t      exp_rdata;

    logic [63:0]             rng_state;
    commit_pkg::bus64_t      next_pc;
    logic                    random_stall;
    int                      cycles;
    int                      errors;
    int                      checks;
    int                      err_mark;
    int                      tests_run;

    // Last entry is an unmapped address
    logic [11:0] addr_pool [0:9] = '{csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MTVEC,
        csr_pkg::CSR_MEPC, csr_pkg::CSR_MCAUSE, csr_pkg::CSR_MTVAL, csr_pkg::CSR_MSCRATCH,
        csr_pkg::CSR_MHARTID, csr_pkg::CSR_MCYCLE, csr_pkg::CSR_MINSTRET, 12'h7C0};

    csr_subsystem #(
        .HART_ID     (HART_ID),
        .RESET_MTVEC (RESET_MTVEC)
    ) csr_subsystem_inst (.*);

    always #4 clk_i = ~clk_i;

    // Prediction for the instruction at commit
    always_comb begin
        known   = 1'b1;
        cur_val = '0;
        case (s_addr)
            csr_pkg::CSR_MSTATUS:  cur_val = (64'(m_mpie) << 7) | (64'(m_mie) << 3);
            csr_pkg::CSR_MTVEC:    cur_val = m_mtvec;
            csr_pkg::CSR_MEPC:     cur_val = m_mepc;
            csr_pkg::CSR_MCAUSE:   cur_val = 64'(m_mcause);
            csr_pkg::CSR_MTVAL:    cur_val = m_mtval;
            csr_pkg::CSR_MSCRATCH: cur_val = m_mscratch;
            csr_pkg::CSR_MHARTID:  cur_val = HART_ID;
            csr_pkg::CSR_MCYCLE:   cur_val = m_mcycle;
            csr_pkg::CSR_MINSTRET: cur_val = m_minstret;
            default:               known   = 1'b0;
        endcase
        csr_op = 1'b0;
        wr_val = s_data;
        case (s_type)
            commit_pkg::CSRRW, commit_pkg::CSRRS, commit_pkg::CSRRC: csr_op = s_valid;
            commit_pkg::CSRRWI, commit_pkg::CSRRSI, commit_pkg::CSRRCI: begin
                csr_op = s_valid;
                wr_val = 64'(s_rs1);
            end
            default: ;
        endcase
        // Set and clear with rs1 = 0 only read
        modify = csr_op && (s_type == commit_pkg::CSRRW || s_type == commit_pkg::CSRRWI
                            || s_rs1 != 5'd0);
        case (s_type)
            commit_pkg::CSRRS, commit_pkg::CSRRSI: new_val = cur_val | wr_val;
            commit_pkg::CSRRC, commit_pkg::CSRRCI: new_val = cur_val & ~wr_val;
            default:                               new_val = wr_val;
        endcase
        trap = (s_valid && (s_xcpt || s_type == commit_pkg::ECALL || s_type == commit_pkg::EBREAK))
               || (modify && (!known || s_addr[11:10] == 2'b11));
        mret = s_valid && s_type == commit_pkg::MRET;
        if (s_xcpt) begin
            cause = s_cause;
        end else if (s_type == commit_pkg::ECALL) begin
            cause = 6'd11;
        end else if (s_type == commit_pkg::EBREAK) begin
            cause = 6'd3;
        end else begin
            cause = 6'd2;
        end
        exp_retire   = s_valid && !s_xcpt;
        exp_redirect = trap || mret;
        exp_rpc      = trap ? (m_mtvec & ~64'h3) : (mret ? m_mepc : '0);
        exp_rvalid   = csr_op && !trap;
        exp_rdata    = exp_rvalid ? cur_val : '0;
    end

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            m_mie      <= 1'b0;
            m_mpie     <= 1'b0;
            m_mtvec    <= RESET_MTVEC;
            m_mepc     <= '0;
            m_mcause   <= '0;
            m_mtval    <= '0;
            m_mscratch <= '0;
            m_mcycle   <= '0;
            m_minstret <= '0;
            s_valid    <= 1'b0;
            s_xcpt     <= 1'b0;
        end else begin
            m_mcycle <= m_mcycle + 1;
            if (exp_retire && !trap) begin
                m_minstret <= m_minstret + 1;
            end
            if (trap) begin
                m_mepc   <= s_pc;
                m_mcause <= cause;
                m_mtval  <= s_xcpt ? s_tval : '0;
                m_mpie   <= m_mie;
                m_mie    <= 1'b0;
            end else if (mret) begin
                m_mie  <= m_mpie;
                m_mpie <= 1'b1;
            end else if (modify) begin
                case (s_addr)
                    csr_pkg::CSR_MSTATUS: begin
                        m_mie  <= new_val[3];
                        m_mpie <= new_val[7];
                    end
                    csr_pkg::CSR_MTVEC:    m_mtvec    <= new_val;
                    csr_pkg::CSR_MEPC:     m_mepc     <= new_val;
                    csr_pkg::CSR_MCAUSE:   m_mcause   <= new_val[5:0];
                    csr_pkg::CSR_MTVAL:    m_mtval    <= new_val;
                    csr_pkg::CSR_MSCRATCH: m_mscratch <= new_val;
                    csr_pkg::CSR_MCYCLE:   m_mcycle   <= new_val;
                    csr_pkg::CSR_MINSTRET: m_minstret <= new_val;
                    default: ;
                endcase
            end
            // Next slot, empty on a stall or a redirect
            s_valid <= instr_valid_i && !stall_exe_i && !exp_redirect;
            s_xcpt  <= instr_valid_i && xcpt_valid_i && !stall_exe_i && !exp_redirect;
            s_type  <= instr_type_i;
            s_pc    <= pc_i;
            s_rs1   <= rs1_i;
            s_addr  <= csr_addr_i;
            s_data  <= result_i;
            s_cause <= xcpt_cause_i;
            s_tval  <= xcpt_tval_i;
        end
    end

    always @(negedge clk_i) begin
        if (arst_n_i) begin
            checks = checks + 5;
            assert (retire_o === exp_retire)
                else report_mismatch("retire_o", exp_retire, retire_o);
            assert (redirect_o === exp_redirect)
                else report_mismatch("redirect_o", exp_redirect, redirect_o);
            assert (redirect_pc_o === exp_rpc)
                else report_mismatch("redirect_pc_o", exp_rpc, redirect_pc_o);
            assert (csr_rdata_valid_o === exp_rvalid)
                else report_mismatch("csr_rdata_valid_o", exp_rvalid, csr_rdata_valid_o);
            assert (csr_rdata_o === exp_rdata)
                else report_mismatch("csr_rdata_o", exp_rdata, csr_rdata_o);
        end
    end

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        errors = errors + 1;
        $display("FAIL %0t ns %s expected %h actual %h", $time, name, exp_v, act_v);
    endtask

    function automatic logic [63:0] rand64();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    // Hold one instruction at the inputs until a cycle without stall takes it
    task automatic issue(input commit_pkg::instr_type_t t, input logic [11:0] addr,
                         input logic [4:0] rs1, input commit_pkg::bus64_t data);
        logic stalled;
        instr_valid_i = 1'b1;
        instr_type_i  = t;
        pc_i          = next_pc;
        rs1_i         = rs1;
        csr_addr_i    = addr;
        result_i      = data;
        do begin
            stalled     = random_stall && (rand64() % 4 == 0);
            stall_exe_i = stalled;
            @(posedge clk_i);
            #1;
        end while (stalled);
        instr_valid_i = 1'b0;
        stall_exe_i   = 1'b0;
        xcpt_valid_i  = 1'b0;
        next_pc       = next_pc + 4;
    endtask

    task automatic issue_faulting(input logic [5:0] code, input commit_pkg::bus64_t tval);
        xcpt_valid_i = 1'b1;
        xcpt_cause_i = code;
        xcpt_tval_i  = tval;
        issue(commit_pkg::OTHER, 12'h000, 5'd0, '0);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic end_test(input string name);
        idle(2);
        tests_run = tests_run + 1;
        $display("Test %0d %s: %0d errors", tests_run, name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        commit_pkg::bus64_t value;
        clk_i         = 1'b0;
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_type_i  = commit_pkg::OTHER;
        pc_i          = '0;
        rs1_i         = '0;
        csr_addr_i    = '0;
        result_i      = '0;
        xcpt_valid_i  = 1'b0;
        xcpt_cause_i  = '0;
        xcpt_tval_i   = '0;
        stall_exe_i   = 1'b0;
        rng_state     = 64'd57;
        next_pc       = 64'h1000;
        random_stall  = 1'b0;
        cycles        = 0;
        errors        = 0;
        checks        = 0;
        err_mark      = 0;
        tests_run     = 0;
        repeat (16) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        idle(1);

        value = rand64();
        issue(commit_pkg::CSRRW, csr_pkg::CSR_MSCRATCH, 5'd1, value);
        issue(commit_pkg::CSRRS, csr_pkg::CSR_MSCRATCH, 5'd0, '0);
        end_test("mscratch write and read");

        issue(commit_pkg::CSRRSI, csr_pkg::CSR_MSCRATCH, 5'h15, '0);
        issue(commit_pkg::CSRRCI, csr_pkg::CSR_MSCRATCH, 5'h05, '0);
        issue(commit_pkg::CSRRCI, csr_pkg::CSR_MSCRATCH, 5'd0, '0);
        issue(commit_pkg::CSRRS, csr_pkg::CSR_MSCRATCH, 5'd0, '0);
        end_test("immediate set and clear");

        // MIE on, so the trap moves it into MPIE
        issue(commit_pkg::CSRRSI, csr_pkg::CSR_MSTATUS, 5'd8, '0);
        issue(commit_pkg::ECALL, 12'h000, 5'd0, '0);
        issue(commit_pkg::OTHER, 12'h000, 5'd0, '0);
        issue(commit_pkg::CSRRS, csr_pkg::CSR_MEPC, 5'd0, '0);
        issue(commit_pkg::CSRRS, csr_pkg::CSR_MCAUSE, 5'd0, '0);
        issue(commit_pkg::MRET, 12'h000, 5'd0, '0);
        issue(commit_pkg::OTHER, 12'h000, 5'd0, '0);
        issue(commit_pkg::CSRRS, csr_pkg::CSR_MSTATUS, 5'd0, '0);
        issue(commit_pkg::EBREAK, 12'h000, 5'd0, '0);
        issue(commit_pkg::OTHER, 12'h000, 5'd0, '0);
        issue(commit_pkg::CSRRS, csr_pkg::CSR_MCAUSE, 5'd0, '0);
        issue(commit_pkg::CSRRS, csr_pkg::CSR_MEPC, 5'd0, '0);
        end_test("ecall, ebreak and mret");

        issue(commit_pkg::CSRRW, csr_pkg::CSR_MHARTID, 5'd1, rand64());
        issue(commit_pkg::OTHER, 12'h000, 5'd0, '0);
        issue(commit_pkg::CSRRS, csr_pkg::CSR_MHARTID, 5'd0, '0);
        issue(commit_pkg::CSRRS, csr_pkg::CSR_MCAUSE, 5'd0, '0);
        issue_faulting(6'd5, rand64());
        issue(commit_pkg::OTHER, 12'h000, 5'd0, '0);
        issue(commit_pkg::CSRRS, csr_pkg::CSR_MCAUSE, 5'd0, '0);
        issue(commit_pkg::CSRRS, csr_pkg::CSR_MTVAL, 5'd0, '0);
        end_test("illegal write and input exception");

        issue(commit_pkg::CSRRS, csr_pkg::CSR_MINSTRET, 5'd0, '0);
        repeat (3) issue(commit_pkg::OTHER, 12'h000, 5'd0, '0);
        idle(2);
        issue(commit_pkg::ECALL, 12'h000, 5'd0, '0);
        issue(commit_pkg::OTHER, 12'h000, 5'd0, '0);
        issue(commit_pkg::CSRRS, csr_pkg::CSR_MINSTRET, 5'd0, '0);
        end_test("minstret counting");

        random_stall = 1'b1;
        repeat (40) begin
            if (rand64() % 8 == 0) begin
                xcpt_valid_i = 1'b1;
                xcpt_cause_i = 6'(rand64() % 16);
                xcpt_tval_i  = rand64();
            end
            issue(commit_pkg::instr_type_t'(4'(rand64() % 12)),
                  addr_pool[4'(rand64() % 10)], 5'(rand64() % 32), rand64());
        end
        random_stall = 1'b0;
        end_test("random stalls and flushes");

        $display("Done: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: tb.f
design/csr_pkg.sv
design/commit_pkg.sv
design/wb_commit_reg.sv
design/csr_interface.sv
design/csr_regfile.sv
design/csr_subsystem.sv
bench/csr_subsystem_tb.sv
